// File: tb/tb_clkgen.sv
/*
 * clock and reset source for the qla testbench
 * rst is synchronous active high, released 1 ns after the last reset edge
 */

module tb_clkgen #(
    parameter real PERIOD_NS  = 8.0,   // sysclk period
    parameter int  RST_CYCLES = 4      // rising edges held in reset
) (
    output logic sysclk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        sysclk = 1'b0;
        forever #(PERIOD_NS / 2.0) sysclk = ~sysclk;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge sysclk);
        #1 rst = 1'b0;      // same offset as the other stimulus
    end

endmodule

// File: tb/tb_qla.sv
/*
 * qla testbench top
 * every task drives the bus for one cycle, 1 ns after the rising edge
 * the checker compares all reads and amp levels on its own
 */

`include "qla_config.svh"

module tb_qla;

    timeunit 1ns;
    timeprecision 1ps;

    import qla_pkg::*;

    localparam int TEST_CYCLES = 150;                    // all tests plus slack
    localparam int WATCHDOG_NS = TEST_CYCLES * 8 + 400;

    logic        sysclk;
    logic        rst;
    logic        reg_wen;
    logic [15:0] reg_waddr;
    logic [31:0] reg_wdata;
    logic [15:0] reg_raddr;
    logic [31:0] reg_rdata;
    logic [3:0]  wenid;
    logic        adc_strobe;
    axis_cur_t   adc_cur;
    axis_bits_t  amp_enable;
    axis_bits_t  amp_disable;
    int          err_cnt;
    int          chk_cnt;
    int          err_base;      // errors before the running test
    int          seed;

    tb_clkgen #(.PERIOD_NS(8.0), .RST_CYCLES(4)) u_clk (.sysclk(sysclk), .rst(rst));

    qla_top u_dut (
        .sysclk(sysclk), .rst(rst),
        .reg_wen(reg_wen), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata),
        .reg_raddr(reg_raddr), .reg_rdata(reg_rdata), .wenid(wenid),
        .adc_strobe(adc_strobe), .adc_cur(adc_cur),
        .amp_enable(amp_enable), .amp_disable(amp_disable)
    );

    tb_qla_checker u_chk (
        .sysclk(sysclk), .rst(rst),
        .reg_wen(reg_wen), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata),
        .reg_raddr(reg_raddr), .reg_rdata(reg_rdata), .wenid(wenid),
        .adc_strobe(adc_strobe), .adc_cur(adc_cur),
        .amp_enable(amp_enable), .amp_disable(amp_disable),
        .err_cnt(err_cnt), .chk_cnt(chk_cnt)
    );

    // ----------------------------------------------------------------------
    // bus helpers
    function automatic logic [15:0] reg_addr(input logic [3:0] space, input int ch,
                                             input logic [3:0] off);
        return {space, 4'd0, 4'(ch), off};
    endfunction

    task automatic idle_cycle();
        @(posedge sysclk);
        #1;
        reg_wen    = 1'b0;
        adc_strobe = 1'b0;
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [31:0] data);
        @(posedge sysclk);
        #1;
        reg_wen    = 1'b1;
        reg_waddr  = addr;
        reg_wdata  = data;
        adc_strobe = 1'b0;
    endtask

    task automatic read_reg(input logic [15:0] addr);
        @(posedge sysclk);
        #1;
        reg_wen    = 1'b0;
        adc_strobe = 1'b0;
        reg_raddr  = addr;      // checker compares at the falling edge
    endtask

    // one adc set with bad axes well above the margin and others below it
    task automatic strobe_sample(input logic [`QLA_NUM_AXES:1] bad, input logic any);
        logic [15:0] mag;
        @(posedge sysclk);
        #1;
        for (int i = 1; i <= `QLA_NUM_AXES; i++) begin
            if (any)
                adc_cur.ax[i] = 16'($random(seed));
            else begin
                if (bad[i])
                    mag = 16'd300 + 16'($random(seed) & 32'h3fff);
                else
                    mag = 16'($random(seed) & 32'h00ff);
                adc_cur.ax[i] = ($random(seed) & 1) ? (16'h8000 + mag) : (16'h8000 - mag);
            end
        end
        reg_wen    = 1'b0;
        adc_strobe = 1'b1;
    endtask

    task automatic end_test(input string name);
        idle_cycle();
        @(negedge sysclk);
        #1;
        $display("test %s: %0d errors", name, err_cnt - err_base);
        err_base = err_cnt;
    endtask

    // ----------------------------------------------------------------------
    // tests
    initial begin
        seed       = 32'ha30f696a;
        reg_wen    = 1'b0;
        reg_waddr  = '0;
        reg_wdata  = '0;
        reg_raddr  = '0;
        wenid      = 4'h5;
        adc_strobe = 1'b0;
        adc_cur    = {`QLA_NUM_AXES{16'h8000}};
        err_base   = 0;
        @(negedge rst);

        // reset values
        read_reg(reg_addr(`QLA_SPACE_MAIN, 0, `QLA_OFF_STATUS));
        for (int ch = 1; ch <= `QLA_NUM_AXES; ch++) begin
            read_reg(reg_addr(`QLA_SPACE_MAIN, ch, `QLA_OFF_ADC_DATA));
            read_reg(reg_addr(`QLA_SPACE_MAIN, ch, `QLA_OFF_DAC_CTRL));
        end
        end_test("reset_values");

        // command write and readback then writes that must miss
        for (int ch = 1; ch <= `QLA_NUM_AXES; ch++) begin
            write_reg(reg_addr(`QLA_SPACE_MAIN, ch, `QLA_OFF_DAC_CTRL),
                      {16'hbeef, 16'h8000 + 16'(ch * 16'h0111)});
            read_reg(reg_addr(`QLA_SPACE_MAIN, ch, `QLA_OFF_DAC_CTRL));
        end
        write_reg(reg_addr(4'h1, 1, `QLA_OFF_DAC_CTRL), 32'h0000_1234);   // other space
        write_reg(reg_addr(`QLA_SPACE_MAIN, 5, `QLA_OFF_DAC_CTRL), 32'h0000_2345);
        write_reg(reg_addr(`QLA_SPACE_MAIN, 2, 4'd2), 32'h0000_3456);     // unmapped offset
        write_reg(reg_addr(`QLA_SPACE_MAIN, 3, `QLA_OFF_ADC_DATA), 32'h0000_4567);
        for (int ch = 1; ch <= `QLA_NUM_AXES; ch++)
            read_reg(reg_addr(`QLA_SPACE_MAIN, ch, `QLA_OFF_DAC_CTRL));
        read_reg(reg_addr(4'h1, 1, `QLA_OFF_DAC_CTRL));
        end_test("command_regs");

        // random feedback read back the cycle after each capture
        repeat (8) begin
            strobe_sample('0, 1'b1);
            for (int ch = 1; ch <= `QLA_NUM_AXES; ch++)
                read_reg(reg_addr(`QLA_SPACE_MAIN, ch, `QLA_OFF_ADC_DATA));
            read_reg(reg_addr(`QLA_SPACE_MAIN, 0, `QLA_OFF_STATUS));
        end
        end_test("feedback_capture");

        // zero commands and clear everything before walking axis 2 to a trip
        for (int ch = 1; ch <= `QLA_NUM_AXES; ch++)
            write_reg(reg_addr(`QLA_SPACE_MAIN, ch, `QLA_OFF_DAC_CTRL), 32'h0000_8000);
        write_reg(reg_addr(`QLA_SPACE_MAIN, 0, `QLA_OFF_STATUS), 32'h0000_000f);
        // full-scale command on axis 1 where twice the command needs 17 bits
        write_reg(reg_addr(`QLA_SPACE_MAIN, 1, `QLA_OFF_DAC_CTRL), 32'h0000_0000);
        repeat (`QLA_SAFETY_TRIP_COUNT) strobe_sample(4'b0001, 1'b0);
        write_reg(reg_addr(`QLA_SPACE_MAIN, 1, `QLA_OFF_DAC_CTRL), 32'h0000_8000);
        read_reg(reg_addr(`QLA_SPACE_MAIN, 0, `QLA_OFF_STATUS));
        strobe_sample(4'b0010, 1'b0);
        strobe_sample(4'b0010, 1'b0);
        strobe_sample(4'b0000, 1'b0);       // breaks the run so no trip
        read_reg(reg_addr(`QLA_SPACE_MAIN, 0, `QLA_OFF_STATUS));
        repeat (`QLA_SAFETY_TRIP_COUNT) strobe_sample(4'b0010, 1'b0);
        idle_cycle();
        read_reg(reg_addr(`QLA_SPACE_MAIN, 0, `QLA_OFF_STATUS));
        end_test("trip_threshold");

        // trip axis 4 too and clear only axis 2
        repeat (`QLA_SAFETY_TRIP_COUNT) strobe_sample(4'b1000, 1'b0);
        idle_cycle();
        read_reg(reg_addr(`QLA_SPACE_MAIN, 0, `QLA_OFF_STATUS));
        write_reg(reg_addr(`QLA_SPACE_MAIN, 0, `QLA_OFF_STATUS), 32'h0000_0007);
        read_reg(reg_addr(`QLA_SPACE_MAIN, 0, `QLA_OFF_STATUS));
        idle_cycle();
        end_test("clear_and_gating");

        $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: tb/tb_qla_checker.sv
/*
 * scoreboard for the qla current path
 * keeps its own model of commands, feedback, enable request and trip
 * counters, fed only from the DUT inputs, and compares every cycle
 * at the falling edge, where reads and amp levels are settled
 */

`include "qla_config.svh"

module tb_qla_checker (
    input  logic                 sysclk,
    input  logic                 rst,
    input  logic                 reg_wen,
    input  logic [15:0]          reg_waddr,
    input  logic [31:0]          reg_wdata,
    input  logic [15:0]          reg_raddr,
    input  logic [31:0]          reg_rdata,
    input  logic [3:0]           wenid,
    input  logic                 adc_strobe,
    input  qla_pkg::axis_cur_t   adc_cur,
    input  qla_pkg::axis_bits_t  amp_enable,
    input  qla_pkg::axis_bits_t  amp_disable,
    output int                   err_cnt,      // mismatches so far
    output int                   chk_cnt       // compares so far
);

    timeunit 1ns;
    timeprecision 1ps;

    import qla_pkg::*;

    // ----------------------------------------------------------------------
    // model state
    logic [15:0]          cmd_m [1:`QLA_NUM_AXES];   // commanded current
    logic [15:0]          fb_m  [1:`QLA_NUM_AXES];   // last captured feedback
    logic [`QLA_NUM_AXES:1] req_m;                   // enable request
    logic [`QLA_NUM_AXES:1] trip_m;                  // latched disables
    int                   cnt_m [1:`QLA_NUM_AXES];   // consecutive bad samples
    logic                 sample_m;                  // a capture happened last edge

    // distance from offset-binary zero in signed int math
    function automatic int dist_from_zero(input logic [15:0] w);
        int d;
        d = int'(w) - 32768;
        return (d < 0) ? -d : d;
    endfunction

    // expected read data for any address from model state
    function automatic logic [31:0] ref_rdata(input logic [15:0] addr);
        logic [31:0] r;
        int          ch;
        r  = '0;
        ch = int'(addr[7:4]);
        if (addr[15:12] == `QLA_SPACE_MAIN) begin
            if (ch == 0) begin
                if (addr[3:0] == `QLA_OFF_STATUS) begin
                    r[27:24] = ~wenid;      // board id
                    r[7:4]   = req_m;
                    r[3:0]   = trip_m;
                end
            end else if (ch <= `QLA_NUM_AXES) begin
                if (addr[3:0] == `QLA_OFF_ADC_DATA)
                    r[15:0] = fb_m[ch];
                else if (addr[3:0] == `QLA_OFF_DAC_CTRL)
                    r[15:0] = cmd_m[ch];
            end
        end
        return r;
    endfunction

    // requested axes that are not tripped
    function automatic logic [`QLA_NUM_AXES:1] ref_enable();
        return req_m & ~trip_m;
    endfunction

    // ----------------------------------------------------------------------
    // model update with inputs sampled at the rising edge
    always @(posedge sysclk) begin : model_update
        logic                   status_wr;
        logic                   main_wr;
        logic [`QLA_NUM_AXES:1] clr;
        int                     wch;
        status_wr = reg_wen && (reg_waddr[15:12] == `QLA_SPACE_MAIN) &&
                    (reg_waddr[7:4] == 4'd0) && (reg_waddr[3:0] == `QLA_OFF_STATUS);
        main_wr   = reg_wen && (reg_waddr[15:12] == `QLA_SPACE_MAIN);
        wch       = int'(reg_waddr[7:4]);
        clr       = status_wr ? reg_wdata[`QLA_NUM_AXES-1:0] : '0;
        if (rst) begin
            for (int i = 1; i <= `QLA_NUM_AXES; i++) begin
                cmd_m[i] = `QLA_CUR_ZERO;
                fb_m[i]  = `QLA_CUR_ZERO;
                cnt_m[i] = 0;
            end
            req_m    = '0;
            trip_m   = '0;
            sample_m = 1'b0;
        end else begin
            // safety check sees last edge's capture against current commands
            for (int i = 1; i <= `QLA_NUM_AXES; i++) begin
                if (clr[i]) begin
                    trip_m[i] = 1'b0;       // clear beats a sample
                    cnt_m[i]  = 0;
                end else if (sample_m && !trip_m[i]) begin
                    if (dist_from_zero(fb_m[i]) >
                        2 * dist_from_zero(cmd_m[i]) + int'(`QLA_SAFETY_MARGIN)) begin
                        cnt_m[i]++;
                        if (cnt_m[i] >= `QLA_SAFETY_TRIP_COUNT)
                            trip_m[i] = 1'b1;
                    end else begin
                        cnt_m[i] = 0;
                    end
                end
            end
            if (status_wr)
                req_m = reg_wdata[`QLA_NUM_AXES-1:0];
            if (main_wr && wch >= 1 && wch <= `QLA_NUM_AXES &&
                reg_waddr[3:0] == `QLA_OFF_DAC_CTRL)
                cmd_m[wch] = reg_wdata[15:0];
            if (adc_strobe) begin
                for (int i = 1; i <= `QLA_NUM_AXES; i++)
                    fb_m[i] = adc_cur.ax[i];
            end
            sample_m = adc_strobe;
        end
    end

    // ----------------------------------------------------------------------
    // compare
    task automatic compare_val(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        chk_cnt++;
        if (act_v !== exp_v) begin
            err_cnt++;
            $display("[FAIL] %0d ns %s expected %h actual %h", $time, name, exp_v, act_v);
        end
    endtask

    always @(negedge sysclk) begin
        if (!rst) begin
            compare_val($sformatf("reg_rdata @%h", reg_raddr), ref_rdata(reg_raddr),
                        reg_rdata);
            compare_val("amp_disable", 32'(trip_m), 32'(amp_disable));
            compare_val("amp_enable", 32'(ref_enable()), 32'(amp_enable));
        end
    end

endmodule

// File: verilog/adc_feedback.sv
/*
 * current feedback capture
 * adc_strobe is a one-cycle pulse with all four adc words valid
 * the whole set is taken at once, a strobe every cycle is fine
 * fb_valid follows one cycle later, in step with cur_fb and fb_mag
 */

`include "qla_config.svh"

module adc_feedback (
    input  logic                 sysclk,
    input  logic                 rst,
    input  logic                 adc_strobe,   // new conversion set
    input  qla_pkg::axis_cur_t   adc_cur,
    output qla_pkg::axis_cur_t   cur_fb,       // last captured set
    output qla_pkg::axis_mag_t   fb_mag,
    output logic                 fb_valid      // one-cycle sample pulse
);

    import qla_pkg::*;

    // ----------------------------------------------------------------------
    // capture stage
    // magnitudes come from the raw inputs so they line up with cur_fb
    always_ff @(posedge sysclk) begin
        if (rst) begin
            for (int i = 1; i <= `QLA_NUM_AXES; i++) begin
                cur_fb.ax[i] <= `QLA_CUR_ZERO;
                fb_mag.ax[i] <= '0;
            end
        end else if (adc_strobe) begin
            for (int i = 1; i <= `QLA_NUM_AXES; i++) begin
                cur_fb.ax[i] <= adc_cur.ax[i];
                fb_mag.ax[i] <= cur_mag(adc_cur.ax[i]);
            end
        end
    end

    // sample pulse for the safety monitor
    always_ff @(posedge sysclk) begin
        if (rst)
            fb_valid <= 1'b0;
        else
            fb_valid <= adc_strobe;     // high only for strobed cycles
    end

endmodule

// File: verilog/board_regs.sv
/*
 * channel 0 board status and the read data mux
 * status write: wdata[3:0] is the amp enable request, and every 1 bit
 * also pulses clear_disable for that axis in the write cycle
 * reads are combinational from registered state, other spaces read 0
 */

`include "qla_config.svh"

module board_regs (
    input  logic                 sysclk,
    input  logic                 rst,
    input  logic                 reg_wen,
    input  logic [15:0]          reg_waddr,
    input  logic [31:0]          reg_wdata,
    input  logic [15:0]          reg_raddr,
    output logic [31:0]          reg_rdata,
    input  logic [3:0]           wenid,          // rotary switch, active low
    input  qla_pkg::axis_cur_t   cur_cmd,
    input  qla_pkg::axis_cur_t   cur_fb,
    input  qla_pkg::axis_bits_t  amp_disable,
    output qla_pkg::axis_bits_t  clear_disable,
    output qla_pkg::axis_bits_t  amp_enable
);

    import qla_pkg::*;

    // ----------------------------------------------------------------------
    // status write
    logic       status_wr;
    axis_bits_t amp_req_q;      // host enable request

    assign status_wr = reg_wen &&
                       (reg_waddr[15:12] == `QLA_SPACE_MAIN) &&
                       (reg_waddr[7:4] == 4'd0) &&
                       (reg_waddr[3:0] == `QLA_OFF_STATUS);

    always_ff @(posedge sysclk) begin
        if (rst)
            amp_req_q <= '0;
        else if (status_wr)
            amp_req_q.ax <= reg_wdata[`QLA_NUM_AXES-1:0];
    end

    // clear pulse rides the write cycle itself
    assign clear_disable.ax = status_wr ? reg_wdata[`QLA_NUM_AXES-1:0] : '0;
    assign amp_enable.ax    = amp_req_q.ax & ~amp_disable.ax;  // tripped axes masked

    // ----------------------------------------------------------------------
    // read mux
    logic [3:0] rchan;
    reg_off_e   roff;

    assign rchan = reg_raddr[7:4];
    assign roff  = reg_off_e'(reg_raddr[3:0]);

    always_comb begin
        reg_rdata = '0;
        if (reg_raddr[15:12] == `QLA_SPACE_MAIN) begin
            if (rchan == 4'd0) begin
                if (reg_raddr[3:0] == `QLA_OFF_STATUS)
                    reg_rdata = {4'd0, ~wenid, 16'd0, amp_req_q.ax, amp_disable.ax};
            end else begin
                for (int i = 1; i <= `QLA_NUM_AXES; i++) begin
                    if (rchan == 4'(i)) begin
                        case (roff)
                            OFF_ADC_DATA: reg_rdata = {16'd0, cur_fb.ax[i]};
                            OFF_DAC_CTRL: reg_rdata = {16'd0, cur_cmd.ax[i]};
                            default:      reg_rdata = '0;   // unmapped offset
                        endcase
                    end
                end
            end
        end
    end

endmodule

// File: verilog/dac_cmd_regs.sv
/*
 * per-axis current command registers
 * written at main space, channel 1..4, offset dac_ctrl, wdata[15:0]
 * command and magnitude are both registered, visible the cycle after
 * the write; no spi side here, the commands leave as parallel words
 */

`include "qla_config.svh"

module dac_cmd_regs (
    input  logic                 sysclk,
    input  logic                 rst,
    input  logic                 reg_wen,
    input  logic [15:0]          reg_waddr,
    input  logic [31:0]          reg_wdata,
    output qla_pkg::axis_cur_t   cur_cmd,    // commands, offset binary
    output qla_pkg::axis_mag_t   cmd_mag     // |cmd - zero| per axis
);

    import qla_pkg::*;

    // ----------------------------------------------------------------------
    // write decode
    logic       wr_main;        // write hits the main space at dac_ctrl
    logic [3:0] wr_chan;

    assign wr_chan = reg_waddr[7:4];
    assign wr_main = reg_wen &&
                     (reg_waddr[15:12] == `QLA_SPACE_MAIN) &&
                     (reg_waddr[3:0] == OFF_DAC_CTRL);

    // new word straight from the bus
    cur_word_t wr_word;
    assign wr_word = reg_wdata[`QLA_CUR_W-1:0];

    // ----------------------------------------------------------------------
    // command storage
    always_ff @(posedge sysclk) begin
        if (rst) begin
            for (int i = 1; i <= `QLA_NUM_AXES; i++) begin
                cur_cmd.ax[i] <= `QLA_CUR_ZERO;    // zero current
                cmd_mag.ax[i] <= '0;
            end
        end else begin
            for (int i = 1; i <= `QLA_NUM_AXES; i++) begin
                if (wr_main && (wr_chan == 4'(i))) begin
                    cur_cmd.ax[i] <= wr_word;
                    cmd_mag.ax[i] <= cur_mag(wr_word);  // same stage as cmd
                end
            end
        end
    end

endmodule

// File: verilog/qla_config.svh
/*
 * constants for the qla register hub and current safety path
 * current words are 16-bit offset binary, 16'h8000 is zero current
 * only the main address space is decoded, other spaces read as zero
 */

`ifndef QLA_CONFIG_SVH
`define QLA_CONFIG_SVH

// ----------------------------------------------------------------------
// board geometry
`define QLA_NUM_AXES            4           // motor axes, channels 1..4
`define QLA_CUR_W               16          // adc/dac current word width
`define QLA_CUR_ZERO            16'h8000    // offset-binary zero current

// ----------------------------------------------------------------------
// register address fields
// addr[15:12] space, addr[7:4] channel, addr[3:0] offset
`define QLA_SPACE_MAIN          4'd0        // main register space
`define QLA_OFF_ADC_DATA        4'd0        // axis feedback readback
`define QLA_OFF_DAC_CTRL        4'd1        // axis current command
`define QLA_OFF_STATUS          4'd0        // board status, channel 0

// ----------------------------------------------------------------------
// safety check
`define QLA_SAFETY_MARGIN       16'd256     // slack above 2x command
`define QLA_SAFETY_TRIP_COUNT   3           // consecutive bad samples to trip

`endif

// File: verilog/qla_pkg.sv
/*
 * shared types for the qla current path
 * per-axis structs keep axis 1 in the lowest field / bit
 * magnitude of 16'h0000 is 32768, so it still fits 16 bits
 */

`include "qla_config.svh"

package qla_pkg;

    // one offset-binary current word
    typedef logic [`QLA_CUR_W-1:0] cur_word_t;

    // unsigned distance from zero current
    typedef logic [`QLA_CUR_W-1:0] cur_mag_t;

    // one word per axis, ax[1] sits in the low 16 bits
    typedef struct packed {
        cur_word_t [`QLA_NUM_AXES:1] ax;
    } axis_cur_t;

    typedef struct packed {
        cur_mag_t [`QLA_NUM_AXES:1] ax;
    } axis_mag_t;

    // one flag per axis, ax[1] is bit 0
    typedef struct packed {
        logic [`QLA_NUM_AXES:1] ax;
    } axis_bits_t;

    // per-axis excess current tracker
    typedef enum logic [1:0] {
        SAFE_OK      = 2'd0,    // last sample fine
        SAFE_WATCH   = 2'd1,    // counting excess samples
        SAFE_TRIPPED = 2'd2     // amp disabled until cleared
    } safety_state_e;

    // axis register offsets, status shares offset 0 on channel 0
    typedef enum logic [3:0] {
        OFF_ADC_DATA = `QLA_OFF_ADC_DATA,
        OFF_DAC_CTRL = `QLA_OFF_DAC_CTRL
    } reg_off_e;

    // |w - zero|, below zero goes the other way round
    function automatic cur_mag_t cur_mag(input cur_word_t w);
        cur_mag_t m;
        if (w >= `QLA_CUR_ZERO)
            m = w - `QLA_CUR_ZERO;
        else
            m = `QLA_CUR_ZERO - w;
        return m;
    endfunction

endpackage

// File: verilog/qla_top.sv
/*
 * qla current path top level
 * command regs and feedback capture run side by side, the safety
 * monitor combines them, board regs close the loop to the host bus
 * single clock domain, strobes and levels only, no handshake
 */

module qla_top (
    input  logic                 sysclk,
    input  logic                 rst,

    // host register bus
    input  logic                 reg_wen,     // one-cycle write strobe
    input  logic [15:0]          reg_waddr,
    input  logic [31:0]          reg_wdata,
    input  logic [15:0]          reg_raddr,
    output logic [31:0]          reg_rdata,   // combinational read result

    input  logic [3:0]           wenid,       // board id switch

    // parallel adc set
    input  logic                 adc_strobe,
    input  qla_pkg::axis_cur_t   adc_cur,

    // amplifier control
    output qla_pkg::axis_bits_t  amp_enable,
    output qla_pkg::axis_bits_t  amp_disable
);

    import qla_pkg::*;

    // ----------------------------------------------------------------------
    // internal wires
    axis_cur_t  cur_cmd;
    axis_mag_t  cmd_mag;
    axis_cur_t  cur_fb;
    axis_mag_t  fb_mag;
    logic       fb_valid;
    axis_bits_t clear_disable;     // status write to safety monitor

    // command path
    dac_cmd_regs u_dac (
        .sysclk    (sysclk),
        .rst       (rst),
        .reg_wen   (reg_wen),
        .reg_waddr (reg_waddr),
        .reg_wdata (reg_wdata),
        .cur_cmd   (cur_cmd),
        .cmd_mag   (cmd_mag)
    );

    // feedback path
    adc_feedback u_adc (
        .sysclk     (sysclk),
        .rst        (rst),
        .adc_strobe (adc_strobe),
        .adc_cur    (adc_cur),
        .cur_fb     (cur_fb),
        .fb_mag     (fb_mag),
        .fb_valid   (fb_valid)
    );

    // ----------------------------------------------------------------------
    // safety and board registers
    safety_monitor u_safe (
        .sysclk        (sysclk),
        .rst           (rst),
        .fb_valid      (fb_valid),
        .fb_mag        (fb_mag),
        .cmd_mag       (cmd_mag),
        .clear_disable (clear_disable),
        .amp_disable   (amp_disable)
    );

    board_regs u_chan0 (
        .sysclk        (sysclk),
        .rst           (rst),
        .reg_wen       (reg_wen),
        .reg_waddr     (reg_waddr),
        .reg_wdata     (reg_wdata),
        .reg_raddr     (reg_raddr),
        .reg_rdata     (reg_rdata),
        .wenid         (wenid),
        .cur_cmd       (cur_cmd),
        .cur_fb        (cur_fb),
        .amp_disable   (amp_disable),
        .clear_disable (clear_disable),
        .amp_enable    (amp_enable)
    );

endmodule

// File: verilog/safety_monitor.sv
/*
 * per-axis excess current check
 * a sample is bad when |fb| > 2*|cmd| + margin, done in 18 bits
 * trip count consecutive bad samples latch amp_disable for the axis
 * clear_disable wins over a sample in the same cycle
 */

`include "qla_config.svh"

module safety_monitor (
    input  logic                 sysclk,
    input  logic                 rst,
    input  logic                 fb_valid,       // sample strobe
    input  qla_pkg::axis_mag_t   fb_mag,
    input  qla_pkg::axis_mag_t   cmd_mag,
    input  qla_pkg::axis_bits_t  clear_disable,  // pulse from status write
    output qla_pkg::axis_bits_t  amp_disable     // level, high when tripped
);

    import qla_pkg::*;

    localparam int LIM_W = `QLA_CUR_W + 2;                       // 2x + margin headroom
    localparam int CNT_W = $clog2(`QLA_SAFETY_TRIP_COUNT + 1);

    // ----------------------------------------------------------------------
    // threshold compare
    logic [LIM_W-1:0]         limit [1:`QLA_NUM_AXES];
    logic [`QLA_NUM_AXES:1]   excess;

    always_comb begin
        for (int i = 1; i <= `QLA_NUM_AXES; i++) begin
            limit[i]  = {1'b0, cmd_mag.ax[i], 1'b0} + LIM_W'(`QLA_SAFETY_MARGIN);
            excess[i] = {2'b00, fb_mag.ax[i]} > limit[i];
        end
    end

    // ----------------------------------------------------------------------
    // per-axis state machines
    safety_state_e            state_q [1:`QLA_NUM_AXES];
    logic [CNT_W-1:0]         cnt_q   [1:`QLA_NUM_AXES];  // consecutive bad samples

    always_ff @(posedge sysclk) begin
        if (rst) begin
            for (int i = 1; i <= `QLA_NUM_AXES; i++) begin
                state_q[i] <= SAFE_OK;
                cnt_q[i]   <= '0;
            end
        end else begin
            for (int i = 1; i <= `QLA_NUM_AXES; i++) begin
                if (clear_disable.ax[i]) begin
                    state_q[i] <= SAFE_OK;      // host clear, start over
                    cnt_q[i]   <= '0;
                end else if (fb_valid) begin
                    case (state_q[i])
                        SAFE_OK, SAFE_WATCH: begin
                            if (!excess[i]) begin
                                state_q[i] <= SAFE_OK;
                                cnt_q[i]   <= '0;
                            end else if (cnt_q[i] == CNT_W'(`QLA_SAFETY_TRIP_COUNT - 1)) begin
                                state_q[i] <= SAFE_TRIPPED;     // last one needed
                                cnt_q[i]   <= cnt_q[i] + 1'b1;
                            end else begin
                                state_q[i] <= SAFE_WATCH;
                                cnt_q[i]   <= cnt_q[i] + 1'b1;
                            end
                        end
                        SAFE_TRIPPED: ;                 // held until cleared
                        default: begin
                            state_q[i] <= SAFE_OK;      // unused encoding
                            cnt_q[i]   <= '0;
                        end
                    endcase
                end
            end
        end
    end

    // disable level straight from state
    always_comb begin
        for (int i = 1; i <= `QLA_NUM_AXES; i++)
            amp_disable.ax[i] = (state_q[i] == SAFE_TRIPPED);
    end

endmodule

// File: vlog.f
+incdir+verilog
verilog/qla_pkg.sv
verilog/dac_cmd_regs.sv
verilog/adc_feedback.sv
verilog/safety_monitor.sv
verilog/board_regs.sv
verilog/qla_top.sv
tb/tb_clkgen.sv
tb/tb_qla_checker.sv
tb/tb_qla.sv
